// ==== vr_replica_top.f ====
+incdir+logic
logic/vr_pkg.sv
logic/vr_msg_if.sv
logic/vr_dispatch.sv
logic/vr_state_regs.sv
logic/vr_prepare_eng.sv
logic/vr_commit_eng.sv
logic/vr_log_mem.sv
logic/vr_reply_merger.sv
logic/vr_replica_top.sv
sim/vr_replica_sva.sv
sim/tb_vr_replica.sv

// ==== Makefile ====
VERILATOR ?= verilator
TOP       ?= tb_vr_replica
FILELIST  ?= vr_replica_top.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert
SIM_ARGS  ?= +verilator+error+limit+1000

.PHONY: lint sim clean

lint:
	$(VERILATOR) --lint-only --timing --top-module $(TOP) -f $(FILELIST)

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR) -o $(TOP)
	-./$(BUILD_DIR)/$(TOP) $(SIM_ARGS) > $(LOG) 2>&1
	@cat $(LOG)
	@if grep -q "Simulation failed" $(LOG) || ! grep -q "Simulation passed" $(LOG); then \
		echo "Run failed, see $(LOG)"; exit 1; fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// ==== sim/tb_vr_replica.sv ====
`include "vr_macros.svh"
`timescale 1ns/100ps

module tb_vr_replica;
    import vr_pkg::*;

    localparam logic [31:0] SEED          = 32'd51636;
    localparam int          IN_TIMEOUT    = 200;
    localparam int          DRAIN_TIMEOUT = 1000;
    localparam int          MIX_MSGS      = 48;

    typedef struct packed {
        vr_view_t    view;
        vr_op_t      op;
        vr_payload_t payload;
    } exp_t;

    logic         clk;
    logic         rst;
    logic         in_val;
    logic         in_rdy;
    vr_msg_type_e in_msg_type;
    vr_view_t     in_view;
    vr_op_t       in_op_num;
    vr_payload_t  in_payload;
    logic         out_val;
    logic         out_rdy;
    vr_msg_type_e out_msg_type;
    vr_view_t     out_view;
    vr_op_t       out_op_num;
    vr_payload_t  out_payload;

    vr_view_t     m_view;      // Model state.
    vr_op_t       m_last;
    vr_op_t       m_commit;
    vr_payload_t  m_log [`VR_LOG_DEPTH];
    exp_t         prep_q[$];   // Expected prepare-oks.
    exp_t         ack_q[$];    // Expected commit-acks.

    logic [31:0]  rng;
    logic [31:0]  stall_rng;
    logic         stall_en;
    int           errors;
    int           checked;
    int           test_no;
    int           mark_errors;
    int           mark_checked;

    vr_replica_top i_vr_replica_top (.*);

    // ####################################################################
    // Clock, output stalls and reply monitor.
    // ####################################################################

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    function automatic logic [31:0] next_random(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    initial begin
        out_rdy   = 1'b1;
        stall_rng = SEED;
        forever begin
            @(posedge clk);
            #1;
            if (stall_en) begin
                stall_rng = next_random(stall_rng);
                out_rdy   = stall_rng[4];  // Ready about half the time.
            end else begin
                out_rdy = 1'b1;
            end
        end
    end

    task automatic check_field(input string name, input logic [31:0] got,
                               input logic [31:0] want);
        assert (got === want) else begin
            errors++;
            $display("CHECK FAILED at %0t: %s is %0h, expected %0h", $time, name, got, want);
        end
    endtask

    task automatic check_reply();
        exp_t exp;
        logic found;
        found = 1'b0;
        exp   = '0;
        if (out_msg_type == PREPARE_OK && prep_q.size() > 0) begin
            exp   = prep_q.pop_front();
            found = 1'b1;
        end else if (out_msg_type == COMMIT_ACK && ack_q.size() > 0) begin
            exp   = ack_q.pop_front();
            found = 1'b1;
        end
        assert (found) else begin
            errors++;
            $display("Unexpected reply of type %0d for op %0d at %0t",
                     out_msg_type, out_op_num, $time);
        end
        if (found) begin
            checked++;
            check_field("out_view", 32'(out_view), 32'(exp.view));
            check_field("out_op_num", 32'(out_op_num), 32'(exp.op));
            check_field("out_payload", out_payload, exp.payload);
        end
    endtask

    // Outputs are steady at the falling edge, the transfer follows.
    always @(negedge clk) begin
        if (!rst && out_val && out_rdy) begin
            check_reply();
        end
    end

    // ####################################################################
    // Reference model and stimulus tasks.
    // ####################################################################

    task automatic model_accept(input vr_msg_type_e t, input vr_view_t v,
                                input vr_op_t op, input vr_payload_t pl);
        exp_t         e;
        vr_log_addr_t idx;
        idx       = op[$bits(vr_log_addr_t)-1:0];
        e.view    = v;
        e.op      = op;
        e.payload = '0;
        case (t)
            SETUP: begin
                m_view   = v;
                m_last   = '0;
                m_commit = '0;
            end
            PREPARE: begin
                if (v == m_view && op == m_last + 8'd1) begin
                    m_log[idx] = pl;
                    m_last     = op;
                    prep_q.push_back(e);
                end
            end
            COMMIT: begin
                if (v == m_view && op > m_commit && op <= m_last) begin
                    e.payload = m_log[idx];
                    m_commit  = op;
                    ack_q.push_back(e);
                end
            end
            default: ;  // Dropped by the dispatcher.
        endcase
    endtask

    task automatic report_timeout(input string what);
        $display("Timeout at %0t: %s", $time, what);
        $display("Simulation failed");
        $finish;
    endtask

    task automatic send_msg(input vr_msg_type_e t, input vr_view_t v,
                            input vr_op_t op, input vr_payload_t pl);
        int n;
        in_val      = 1'b1;
        in_msg_type = t;
        in_view     = v;
        in_op_num   = op;
        in_payload  = pl;
        for (n = 0; n < IN_TIMEOUT; n++) begin
            @(negedge clk);
            if (in_rdy) break;
        end
        if (n == IN_TIMEOUT) report_timeout("in_rdy stayed low, message not accepted");
        model_accept(t, v, op, pl);
        @(posedge clk);
        #1;
        in_val = 1'b0;
    endtask

    task automatic drain_replies();
        int n;
        int quiet;
        quiet = 0;
        for (n = 0; n < DRAIN_TIMEOUT; n++) begin
            @(negedge clk);
            if (prep_q.size() == 0 && ack_q.size() == 0 && !out_val) quiet++;
            else quiet = 0;
            if (quiet == 4) break;
        end
        if (n == DRAIN_TIMEOUT) report_timeout("expected replies never arrived");
        @(posedge clk);
        #1;
    endtask

    task automatic finish_test(input string name);
        test_no++;
        $display("Test %0d (%s): %0d replies checked, %0d errors",
                 test_no, name, checked - mark_checked, errors - mark_errors);
        mark_checked = checked;
        mark_errors  = errors;
    endtask

    // ####################################################################
    // Test sequence.
    // ####################################################################

    initial begin
        int     i;
        vr_op_t span;
        vr_op_t pick;
        rst          = 1'b1;
        in_val       = 1'b0;
        in_msg_type  = SETUP;
        in_view      = '0;
        in_op_num    = '0;
        in_payload   = '0;
        stall_en     = 1'b0;
        rng          = SEED;
        m_view       = '0;
        m_last       = '0;
        m_commit     = '0;
        errors       = 0;
        checked      = 0;
        test_no      = 0;
        mark_errors  = 0;
        mark_checked = 0;
        repeat (16) @(posedge clk);
        #1;
        rst = 1'b0;

        send_msg(SETUP, 8'd3, 8'd0, 32'd0);
        for (i = 1; i <= 4; i++) begin
            rng = next_random(rng);
            send_msg(PREPARE, 8'd3, vr_op_t'(i), rng);
        end
        drain_replies();
        finish_test("in-order prepares");

        rng = next_random(rng);
        send_msg(PREPARE, 8'd4, 8'd5, rng);  // Wrong view.
        send_msg(PREPARE, 8'd3, 8'd7, rng);  // Op gap.
        send_msg(PREPARE, 8'd3, 8'd5, rng);
        drain_replies();
        check_field("state.last_op", 32'(i_vr_replica_top.state.last_op), 32'(m_last));
        finish_test("rejected prepares");

        send_msg(COMMIT, 8'd3, 8'd2, 32'd0);
        send_msg(COMMIT, 8'd3, 8'd5, 32'd0);
        drain_replies();
        finish_test("valid commits");

        send_msg(COMMIT, 8'd3, 8'd5, 32'd0);
        send_msg(COMMIT, 8'd3, 8'd3, 32'd0);
        send_msg(COMMIT, 8'd3, 8'd9, 32'd0);
        send_msg(vr_msg_type_e'(3'd7), 8'd3, 8'd6, 32'd0);
        drain_replies();
        finish_test("rejected commits");

        stall_en = 1'b1;
        for (i = 0; i < MIX_MSGS; i++) begin
            rng  = next_random(rng);
            span = m_last - m_commit;
            if (rng[0] || span == 0) begin
                rng = next_random(rng);
                send_msg(PREPARE, m_view, m_last + 8'd1, rng);
            end else begin
                pick = m_commit + 8'd1 + vr_op_t'(rng[15:8] % span);
                send_msg(COMMIT, m_view, pick, 32'd0);
            end
        end
        drain_replies();
        stall_en = 1'b0;
        finish_test("interleaved with stalls");

        send_msg(SETUP, 8'd9, 8'd0, 32'd0);
        rng = next_random(rng);
        send_msg(PREPARE, 8'd9, 8'd1, rng);
        rng = next_random(rng);
        send_msg(PREPARE, 8'd9, 8'd2, rng);
        send_msg(COMMIT, 8'd9, 8'd1, 32'd0);
        drain_replies();
        finish_test("second setup");

        errors = errors + i_vr_replica_top.i_vr_replica_sva.fail_count;
        $display("Tests %0d, replies checked %0d, errors %0d", test_no, checked, errors);
        if (errors == 0) begin
            $display("Simulation passed");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

endmodule

// ==== sim/vr_replica_sva.sv ====
`timescale 1ns/100ps

module vr_replica_sva (
    input logic                 clk,
    input logic                 rst,
    input logic                 out_val,
    input logic                 out_rdy,
    input vr_pkg::vr_msg_type_e out_msg_type,
    input vr_pkg::vr_view_t     out_view,
    input vr_pkg::vr_op_t       out_op_num,
    input vr_pkg::vr_payload_t  out_payload
);
    import vr_pkg::*;

    int hold_fails = 0;
    int reset_fails = 0;
    int fail_count;

    assign fail_count = hold_fails + reset_fails;

    // A stalled reply keeps its valid and fields.
    a_hold: assert property (@(posedge clk) disable iff (rst)
        out_val && !out_rdy |=> out_val &&
        $stable({out_msg_type, out_view, out_op_num, out_payload}))
    else begin
        hold_fails++;
        $error("Output reply changed while out_rdy was low.");
    end

    a_reset: assert property (@(posedge clk) rst |=> !out_val)
    else begin
        reset_fails++;
        $error("out_val high right after reset.");
    end

endmodule

bind vr_replica_top vr_replica_sva i_vr_replica_sva (
    .clk          (clk),
    .rst          (rst),
    .out_val      (out_val),
    .out_rdy      (out_rdy),
    .out_msg_type (out_msg_type),
    .out_view     (out_view),
    .out_op_num   (out_op_num),
    .out_payload  (out_payload)
);

// ==== logic/vr_replica_top.sv ====
`timescale 1ns/100ps

module vr_replica_top (
    input  logic                 clk,
    input  logic                 rst,
    input  logic                 in_val,
    output logic                 in_rdy,
    input  vr_pkg::vr_msg_type_e in_msg_type,
    input  vr_pkg::vr_view_t     in_view,
    input  vr_pkg::vr_op_t       in_op_num,
    input  vr_pkg::vr_payload_t  in_payload,
    output logic                 out_val,
    input  logic                 out_rdy,
    output vr_pkg::vr_msg_type_e out_msg_type,
    output vr_pkg::vr_view_t     out_view,
    output vr_pkg::vr_op_t       out_op_num,
    output vr_pkg::vr_payload_t  out_payload
);
    import vr_pkg::*;

    // ####################################################################
    // Internal wiring.
    // ####################################################################

    vr_msg_if prep_req_if ();
    vr_msg_if commit_req_if ();
    vr_msg_if prep_rep_if ();
    vr_msg_if commit_rep_if ();

    logic         setup_wr;
    vr_view_t     setup_view;
    vr_state_t    state;
    logic         last_op_wr;
    vr_op_t       last_op_data;
    logic         commit_wr;
    vr_op_t       commit_data;
    logic         log_wr;
    vr_log_addr_t log_wr_addr;
    vr_payload_t  log_wr_data;
    logic         log_rd;
    vr_log_addr_t log_rd_addr;
    vr_payload_t  log_rd_data;

    // ####################################################################
    // Instances.
    // ####################################################################

    vr_dispatch i_vr_dispatch (
        .clk         (clk),
        .rst         (rst),
        .in_val      (in_val),
        .in_msg_type (in_msg_type),
        .in_view     (in_view),
        .in_op_num   (in_op_num),
        .in_payload  (in_payload),
        .in_rdy      (in_rdy),
        .prep        (prep_req_if.sender),
        .commit      (commit_req_if.sender),
        .setup_wr    (setup_wr),
        .setup_view  (setup_view)
    );

    vr_state_regs i_vr_state_regs (
        .clk          (clk),
        .rst          (rst),
        .setup_wr     (setup_wr),
        .setup_view   (setup_view),
        .last_op_wr   (last_op_wr),
        .last_op_data (last_op_data),
        .commit_wr    (commit_wr),
        .commit_data  (commit_data),
        .state        (state)
    );

    vr_prepare_eng i_vr_prepare_eng (
        .clk          (clk),
        .rst          (rst),
        .state        (state),
        .req          (prep_req_if.receiver),
        .reply        (prep_rep_if.sender),
        .last_op_wr   (last_op_wr),
        .last_op_data (last_op_data),
        .log_wr       (log_wr),
        .log_wr_addr  (log_wr_addr),
        .log_wr_data  (log_wr_data)
    );

    vr_commit_eng i_vr_commit_eng (
        .clk         (clk),
        .rst         (rst),
        .state       (state),
        .log_rd_data (log_rd_data),
        .req         (commit_req_if.receiver),
        .reply       (commit_rep_if.sender),
        .commit_wr   (commit_wr),
        .commit_data (commit_data),
        .log_rd      (log_rd),
        .log_rd_addr (log_rd_addr)
    );

    vr_log_mem i_vr_log_mem (
        .clk     (clk),
        .wr      (log_wr),
        .wr_addr (log_wr_addr),
        .wr_data (log_wr_data),
        .rd      (log_rd),
        .rd_addr (log_rd_addr),
        .rd_data (log_rd_data)
    );

    vr_reply_merger i_vr_reply_merger (
        .clk          (clk),
        .rst          (rst),
        .out_rdy      (out_rdy),
        .prep         (prep_rep_if.receiver),
        .commit       (commit_rep_if.receiver),
        .out_val      (out_val),
        .out_msg_type (out_msg_type),
        .out_view     (out_view),
        .out_op_num   (out_op_num),
        .out_payload  (out_payload)
    );

endmodule

// ==== logic/vr_reply_merger.sv ====
`timescale 1ns/100ps

module vr_reply_merger (
    input  logic                 clk,
    input  logic                 rst,
    input  logic                 out_rdy,
    vr_msg_if.receiver           prep,
    vr_msg_if.receiver           commit,
    output logic                 out_val,
    output vr_pkg::vr_msg_type_e out_msg_type,
    output vr_pkg::vr_view_t     out_view,
    output vr_pkg::vr_op_t       out_op_num,
    output vr_pkg::vr_payload_t  out_payload
);
    import vr_pkg::*;

    logic commit_lock;  // Commit reply granted but not yet taken.
    logic sel_commit;

    // Prepare wins unless a commit is already on the output.
    assign sel_commit = commit_lock || (commit.val && !prep.val);

    assign out_val      = prep.val || commit.val;
    assign out_msg_type = sel_commit ? commit.msg_type : prep.msg_type;
    assign out_view     = sel_commit ? commit.view     : prep.view;
    assign out_op_num   = sel_commit ? commit.op_num   : prep.op_num;
    assign out_payload  = sel_commit ? commit.payload  : prep.payload;

    assign prep.rdy   = out_rdy && !sel_commit;
    assign commit.rdy = out_rdy && sel_commit;

    always_ff @(posedge clk) begin
        if (rst) begin
            commit_lock <= 1'b0;
        end else begin
            commit_lock <= sel_commit && commit.val && !out_rdy;
        end
    end

endmodule

// ==== logic/vr_log_mem.sv ====
`include "vr_macros.svh"
`timescale 1ns/100ps

module vr_log_mem (
    input  logic                 clk,
    input  logic                 wr,
    input  vr_pkg::vr_log_addr_t wr_addr,
    input  vr_pkg::vr_payload_t  wr_data,
    input  logic                 rd,
    input  vr_pkg::vr_log_addr_t rd_addr,
    output vr_pkg::vr_payload_t  rd_data
);
    import vr_pkg::*;

    vr_payload_t mem [`VR_LOG_DEPTH];

    always_ff @(posedge clk) begin
        if (wr) begin
            mem[wr_addr] <= wr_data;
        end
    end

    // Registered read, holds between reads.
    always_ff @(posedge clk) begin
        if (rd) begin
            rd_data <= mem[rd_addr];
        end
    end

endmodule

// ==== logic/vr_commit_eng.sv ====
`timescale 1ns/100ps

module vr_commit_eng (
    input  logic                 clk,
    input  logic                 rst,
    input  vr_pkg::vr_state_t    state,
    input  vr_pkg::vr_payload_t  log_rd_data,
    vr_msg_if.receiver           req,
    vr_msg_if.sender             reply,
    output logic                 commit_wr,
    output vr_pkg::vr_op_t       commit_data,
    output logic                 log_rd,
    output vr_pkg::vr_log_addr_t log_rd_addr
);
    import vr_pkg::*;

    logic     chk;
    logic     rd_wait;   // Log read data is valid this cycle.
    logic     pend;
    logic     accept_ok;
    vr_view_t view_r;
    vr_op_t   op_r;

    assign req.rdy = !(chk || rd_wait || pend);

    // Commit must move forward and stay within the log.
    assign accept_ok = chk && (view_r == state.view) &&
                       (op_r > state.commit_num) && (op_r <= state.last_op);

    assign commit_wr   = accept_ok;
    assign commit_data = op_r;
    assign log_rd      = accept_ok;
    assign log_rd_addr = op_r[$bits(vr_log_addr_t)-1:0];

    // Read register holds its data until the next read, which waits for this reply.
    assign reply.val      = rd_wait || pend;
    assign reply.msg_type = COMMIT_ACK;
    assign reply.view     = view_r;
    assign reply.op_num   = op_r;
    assign reply.payload  = log_rd_data;

    always_ff @(posedge clk) begin
        if (rst) begin
            chk     <= 1'b0;
            rd_wait <= 1'b0;
            pend    <= 1'b0;
        end else begin
            chk     <= req.val && req.rdy;
            rd_wait <= accept_ok;
            pend    <= reply.val && !reply.rdy;
        end
    end

    always_ff @(posedge clk) begin
        if (req.val && req.rdy) begin
            view_r <= req.view;
            op_r   <= req.op_num;
        end
    end

endmodule

// ==== logic/vr_prepare_eng.sv ====
`timescale 1ns/100ps

module vr_prepare_eng (
    input  logic                clk,
    input  logic                rst,
    input  vr_pkg::vr_state_t   state,
    vr_msg_if.receiver          req,
    vr_msg_if.sender            reply,
    output logic                last_op_wr,
    output vr_pkg::vr_op_t      last_op_data,
    output logic                log_wr,
    output vr_pkg::vr_log_addr_t log_wr_addr,
    output vr_pkg::vr_payload_t log_wr_data
);
    import vr_pkg::*;

    logic        chk;       // Check cycle after acceptance.
    logic        pend;      // Reply waiting on the merger.
    logic        accept_ok;
    vr_view_t    view_r;
    vr_op_t      op_r;
    vr_payload_t payload_r;

    assign req.rdy = !(chk || pend);

    // In-order prepare in the current view.
    assign accept_ok = chk && (view_r == state.view) && (op_r == state.last_op + 1'b1);

    assign log_wr       = accept_ok;
    assign log_wr_addr  = op_r[$bits(vr_log_addr_t)-1:0];
    assign log_wr_data  = payload_r;
    assign last_op_wr   = accept_ok;
    assign last_op_data = op_r;

    assign reply.val      = accept_ok || pend;
    assign reply.msg_type = PREPARE_OK;
    assign reply.view     = view_r;
    assign reply.op_num   = op_r;
    assign reply.payload  = '0;

    always_ff @(posedge clk) begin
        if (rst) begin
            chk  <= 1'b0;
            pend <= 1'b0;
        end else begin
            chk  <= req.val && req.rdy;
            pend <= reply.val && !reply.rdy;
        end
    end

    always_ff @(posedge clk) begin
        if (req.val && req.rdy) begin
            view_r    <= req.view;
            op_r      <= req.op_num;
            payload_r <= req.payload;
        end
    end

endmodule

// ==== logic/vr_state_regs.sv ====
`timescale 1ns/100ps

module vr_state_regs (
    input  logic              clk,
    input  logic              rst,
    input  logic              setup_wr,
    input  vr_pkg::vr_view_t  setup_view,
    input  logic              last_op_wr,
    input  vr_pkg::vr_op_t    last_op_data,
    input  logic              commit_wr,
    input  vr_pkg::vr_op_t    commit_data,
    output vr_pkg::vr_state_t state
);
    import vr_pkg::*;

    vr_state_t state_r;

    always_ff @(posedge clk) begin
        if (rst) begin
            state_r <= '0;
        end else if (setup_wr) begin
            // New view starts with an empty log.
            state_r.view       <= setup_view;
            state_r.last_op    <= '0;
            state_r.commit_num <= '0;
        end else begin
            if (last_op_wr) begin
                state_r.last_op <= last_op_data;    // Prepare engine.
            end
            if (commit_wr) begin
                state_r.commit_num <= commit_data;  // Commit engine.
            end
        end
    end

    assign state = state_r;

endmodule

// ==== logic/vr_dispatch.sv ====
`timescale 1ns/100ps

module vr_dispatch (
    input  logic                 clk,
    input  logic                 rst,
    input  logic                 in_val,
    input  vr_pkg::vr_msg_type_e in_msg_type,
    input  vr_pkg::vr_view_t     in_view,
    input  vr_pkg::vr_op_t       in_op_num,
    input  vr_pkg::vr_payload_t  in_payload,
    output logic                 in_rdy,
    vr_msg_if.sender             prep,
    vr_msg_if.sender             commit,
    output logic                 setup_wr,
    output vr_pkg::vr_view_t     setup_view
);
    import vr_pkg::*;

    logic is_prep;
    logic is_commit;
    logic setup_xfer;

    assign is_prep    = (in_msg_type == PREPARE);
    assign is_commit  = (in_msg_type == COMMIT);
    assign setup_xfer = in_val && (in_msg_type == SETUP); // Setup never stalls.

    // Unknown types are swallowed here.
    assign in_rdy = is_prep ? prep.rdy : (is_commit ? commit.rdy : 1'b1);

    assign prep.val      = in_val && is_prep;
    assign prep.msg_type = in_msg_type;
    assign prep.view     = in_view;
    assign prep.op_num   = in_op_num;
    assign prep.payload  = in_payload;

    assign commit.val      = in_val && is_commit;
    assign commit.msg_type = in_msg_type;
    assign commit.view     = in_view;
    assign commit.op_num   = in_op_num;
    assign commit.payload  = in_payload;

    always_ff @(posedge clk) begin
        if (rst) begin
            setup_wr <= 1'b0;
        end else begin
            setup_wr <= setup_xfer; // One-cycle pulse.
        end
    end

    always_ff @(posedge clk) begin
        if (setup_xfer) begin
            setup_view <= in_view;
        end
    end

endmodule

// ==== logic/vr_msg_if.sv ====
`timescale 1ns/100ps

// One-beat replica message with valid/ready.
interface vr_msg_if;
    import vr_pkg::*;

    logic         val;
    logic         rdy;
    vr_msg_type_e msg_type;
    vr_view_t     view;
    vr_op_t       op_num;
    vr_payload_t  payload;

    modport sender (
        output val, msg_type, view, op_num, payload,
        input  rdy
    );

    modport receiver (
        input  val, msg_type, view, op_num, payload,
        output rdy
    );

endinterface

// ==== logic/vr_pkg.sv ====
`include "vr_macros.svh"

package vr_pkg;

    typedef logic [`VR_VIEW_W-1:0]             vr_view_t;
    typedef logic [`VR_OP_W-1:0]               vr_op_t;
    typedef logic [`VR_PAYLOAD_W-1:0]          vr_payload_t;
    typedef logic [$clog2(`VR_LOG_DEPTH)-1:0]  vr_log_addr_t;

    // Codes not listed here are dropped by the dispatcher.
    typedef enum logic [2:0] {
        SETUP      = 3'd1,
        PREPARE    = 3'd2,
        COMMIT     = 3'd3,
        PREPARE_OK = 3'd4,
        COMMIT_ACK = 3'd5
    } vr_msg_type_e;

    typedef struct packed {
        vr_view_t view;
        vr_op_t   last_op;    // Highest op appended to the log.
        vr_op_t   commit_num;
    } vr_state_t;

endpackage

// ==== logic/vr_macros.svh ====
`ifndef VR_MACROS_SVH
`define VR_MACROS_SVH

// View number width.
`define VR_VIEW_W 8

// Operation and commit number width.
`define VR_OP_W 8

`define VR_PAYLOAD_W 32

// Log entries, indexed by the low op bits.
`define VR_LOG_DEPTH 16

`endif
